//--- Makefile
VERILATOR       ?= verilator
TOP             ?= cpu_tb
BUILD_DIR       ?= obj_dir
FILE_LIST       ?= files.f
TIMESCALE       ?= 1ns/1ps
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv testbench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
verilog/cpu_mem_pkg.sv
verilog/cpu_isa_pkg.sv
verilog/program_ram.sv
verilog/instruction_fetch.sv
verilog/execute_unit.sv
verilog/cpu_top.sv
testbench/cpu_tb_checker.sv
testbench/cpu_tb.sv

//--- testbench/cpu_tb.sv
module cpu_tb
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int SCENARIO_COUNT  = 6;
  localparam int SCENARIO_CYCLES = 400;
  localparam int BASE            = DEFAULT_PROGRAM_BASE;

  logic        clk = 1'b0;
  logic        reset;
  logic        load_enable;
  ram_addr_t   load_address;
  word_t       load_data;
  logic        run;
  reg_write_t  reg_write;
  error_code_t error_code;
  logic        halted;
  logic        check_failed;
  logic [31:0] lfsr_state = 32'heff5;
  ram_addr_t   fill_address;  // next free program word

  cpu_top cpu_top_inst (
    .clk(clk),
    .reset(reset),
    .load_enable(load_enable),
    .load_address(load_address),
    .load_data(load_data),
    .run(run),
    .reg_write(reg_write),
    .error_code(error_code),
    .halted(halted)
  );

  cpu_tb_checker checker_inst (
    .clk(clk),
    .reset(reset),
    .run(run),
    .reg_write(reg_write),
    .error_code(error_code),
    .halted(halted),
    .failed(check_failed)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge check_failed) begin
    $display("Regression failed");
    $fatal(1, "stopped at the first failed check");
  end

  initial begin
    #(CLK_PERIOD * SCENARIO_CYCLES * SCENARIO_COUNT);
    $display("Regression failed");
    $fatal(1, "watchdog expired before all scenarios finished");
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [15:0] random_bits(input int width);
    logic [15:0] value;
    logic        feedback;
    int          i;
    value = '0;
    for (i = 0; i < width; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[14:0], feedback};
    end
    return value;
  endfunction

  task automatic pick_range(output reg_index_t start, output logic [2:0] count);
    count = 3'(random_bits(3));
    start = 5'(random_bits(5));
    if ({1'b0, start} + {3'b0, count} >= 6'd32) begin
      start = 5'd31 - {2'b0, count};  // keep the range inside the register file
    end
  endtask

  task automatic load_word(input ram_addr_t address, input word_t data);
    @(posedge clk);
    load_enable  <= 1'b1;
    load_address <= address;
    load_data    <= data;
    checker_inst.set_word(address, data);
  endtask

  task automatic put_instr(input opcode_t op, input logic [7:0] param, input word_t operand);
    load_word(fill_address, {op, param});
    load_word(fill_address + 16'd1, operand);
    fill_address = fill_address + 16'd2;
  endtask

  task automatic put_range(input opcode_t op, input reg_index_t start, input logic [2:0] count,
                           input word_t operand);
    put_instr(op, {count, start}, operand);
  endtask

  // the odd target points at a NUM2REG hidden at halt + 3
  task automatic put_halt();
    ram_addr_t trap_address;
    trap_address = fill_address + 16'd3;
    put_instr(OPCODE_JMP, 8'(random_bits(8)), trap_address);
    load_word(fill_address, 16'h0000);
    load_word(fill_address + 16'd1, {OPCODE_NUM2REG, 8'd0});
    load_word(fill_address + 16'd2, random_bits(16));
    fill_address = fill_address + 16'd4;
  endtask

  task automatic begin_scenario(input string name);
    @(posedge clk);
    reset       <= 1'b1;
    run         <= 1'b0;
    load_enable <= 1'b0;
    checker_inst.clear_model(name);
    repeat (RESET_CYCLES) @(posedge clk);
    reset        <= 1'b0;
    fill_address = ram_addr_t'(BASE);
  endtask

  task automatic execute_program();
    @(posedge clk);
    load_enable <= 1'b0;
    run         <= 1'b1;
    checker_inst.run_model();
    @(negedge clk);
    while (!halted) @(negedge clk);
    checker_inst.final_check();
    repeat (4) @(posedge clk);  // stays halted with run high
  endtask

  initial begin
    reg_index_t start;
    logic [2:0] count;
    reset        = 1'b1;
    run          = 1'b0;
    load_enable  = 1'b0;
    load_address = '0;
    load_data    = '0;

    begin_scenario("num2reg");
    pick_range(start, count);
    put_range(OPCODE_NUM2REG, start, count, random_bits(16));
    pick_range(start, count);
    put_range(OPCODE_NUM2REG, start, count, random_bits(16));
    put_halt();
    execute_program();

    begin_scenario("reg_plus_minus");
    pick_range(start, count);
    put_range(OPCODE_NUM2REG, start, count, random_bits(16));
    put_range(OPCODE_REG_PLUS, start, count, random_bits(16));
    put_range(OPCODE_REG_MINUS, start, count, random_bits(16));
    pick_range(start, count);
    put_range(OPCODE_REG_PLUS, start, count, random_bits(16));
    put_halt();
    execute_program();

    begin_scenario("jumps");
    pick_range(start, count);
    put_range(OPCODE_NUM2REG, start, count, random_bits(16));
    put_instr(OPCODE_JMP, 8'(random_bits(8)), 16'(BASE + 8));  // into the loop body
    put_range(OPCODE_NUM2REG, 5'd20, 3'd3, random_bits(16));  // jumped over
    put_instr(OPCODE_JMP_PLUS, 8'd0, 16'd3);                   // exit to BASE+14
    put_range(OPCODE_REG_PLUS, start, count, random_bits(16)); // loop body
    put_instr(OPCODE_JMP_MINUS, 8'd0, 16'd2);                  // back to the exit jump
    put_range(OPCODE_NUM2REG, 5'd31, 3'd0, random_bits(16));   // jumped over
    put_halt();
    execute_program();

    begin_scenario("wrong_address");
    pick_range(start, count);
    put_range(OPCODE_NUM2REG, start, count, random_bits(16));
    put_halt();
    put_range(OPCODE_REG_PLUS, start, count, random_bits(16)); // never reached
    execute_program();

    begin_scenario("wrong_reg_num");
    put_range(OPCODE_NUM2REG, 5'd0, 3'd7, random_bits(16));
    count = 3'(random_bits(3)) | 3'd1;
    put_range(OPCODE_REG_PLUS, 5'(6'd32 - {3'b0, count}), count, random_bits(16));
    put_halt();
    execute_program();

    // registers written above must read zero again
    begin_scenario("reset_clears");
    put_range(OPCODE_REG_PLUS, 5'd0, 3'd7, random_bits(16));
    put_range(OPCODE_REG_MINUS, 5'd2, 3'd3, random_bits(16));
    put_instr(OPCODE_JMP_MINUS, 8'd0, 16'd40);  // target below the program base
    execute_program();

    if (check_failed) begin
      $display("Regression failed");
      $fatal(1, "a check failed during the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- testbench/cpu_tb_checker.sv
module cpu_tb_checker
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  reg_write_t  reg_write,
  input  error_code_t error_code,
  input  logic        halted,
  output logic        failed
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_STEPS  = 64;
  localparam int MAX_WRITES = MAX_STEPS * 8;

  word_t       model_mem [DEFAULT_RAM_DEPTH];
  word_t       model_regs [REG_COUNT];
  reg_index_t  exp_idx [MAX_WRITES];
  word_t       exp_val [MAX_WRITES];
  int          exp_total;
  int          exp_pos;     // writes seen so far
  error_code_t exp_error;   // error that ends the program
  string       test_name;
  logic        exp_pending;
  reg_index_t  exp_index;
  word_t       exp_value;

  initial failed = 1'b0;

  assign exp_pending = exp_pos < exp_total;
  assign exp_index   = exp_idx[exp_pos];
  assign exp_value   = exp_val[exp_pos];

  always @(posedge clk) begin
    if (reset) begin
      exp_pos <= 0;
    end else if (reg_write.valid) begin
      exp_pos <= exp_pos + 1;
    end
  end

  task automatic clear_model(input string name);
    test_name  = name;
    exp_total  = 0;
    exp_error  = ERROR_NONE;
    model_regs = '{default: '0};
    model_mem  = '{default: '0};
  endtask

  task automatic set_word(input ram_addr_t address, input word_t data);
    if (int'(address) < DEFAULT_RAM_DEPTH) begin
      model_mem[int'(address)] = data;
    end
  endtask

  // walks the program by the PC rules and records every writeback in order
  task automatic run_model();
    int         pc;
    int         steps;
    int         first;
    int         last;
    int         target;
    int         i;
    logic [7:0] op;
    logic [7:0] param;
    word_t      operand;
    word_t      value;
    logic       stop;
    pc    = DEFAULT_PROGRAM_BASE;
    steps = 0;
    stop  = 1'b0;
    while (!stop && steps < MAX_STEPS) begin
      steps = steps + 1;
      if (pc + 1 >= DEFAULT_RAM_DEPTH) begin
        exp_error = ERROR_WRONG_ADDRESS;  // second word past the RAM
        stop      = 1'b1;
      end else begin
        op      = model_mem[pc][15:8];
        param   = model_mem[pc][7:0];
        operand = model_mem[pc + 1];
        first   = int'(param[4:0]);
        last    = first + int'(param[7:5]);
        target  = pc + 2;
        case (op)
          OPCODE_JMP: begin
            target = int'(operand);  // param byte lands above the address width
            if (operand[0]) exp_error = ERROR_WRONG_ADDRESS;
          end
          OPCODE_JMP_PLUS: target = (pc + 2 + 2 * int'(operand)) % 65536;
          OPCODE_JMP_MINUS: begin
            target = pc - 2 * int'(operand);
            if (target < DEFAULT_PROGRAM_BASE) exp_error = ERROR_WRONG_ADDRESS;
          end
          OPCODE_NUM2REG, OPCODE_REG_PLUS, OPCODE_REG_MINUS: begin
            if (last >= REG_COUNT) begin
              exp_error = ERROR_WRONG_REG_NUM;
            end else begin
              for (i = first; i <= last; i++) begin
                if (op == OPCODE_NUM2REG) value = operand;
                else if (op == OPCODE_REG_PLUS) value = model_regs[i] + operand;
                else value = model_regs[i] - operand;
                model_regs[i]      = value;
                exp_idx[exp_total] = reg_index_t'(i);
                exp_val[exp_total] = value;
                exp_total          = exp_total + 1;
              end
            end
          end
          default: target = pc + 2;  // unknown opcode moves on
        endcase
        stop = (exp_error != ERROR_NONE);
        pc   = target;
      end
    end
    if (!stop) begin
      $display("model of %s ran %0d instructions without halting", test_name, MAX_STEPS);
      failed = 1'b1;
    end
  endtask

  task automatic final_check();
    assert (exp_pos == exp_total) else begin
      $display("[ERROR] %s: write count expected %0d, actual %0d", test_name, exp_total, exp_pos);
      failed = 1'b1;
    end
    assert (error_code == exp_error) else begin
      $display("[ERROR] %s: error_code expected %0d, actual %0d", test_name, exp_error,
        error_code);
      failed = 1'b1;
    end
  endtask

  assert property (@(posedge clk) disable iff (reset)
    reg_write.valid |-> (exp_pending && reg_write.index == exp_index
      && reg_write.value == exp_value))
  else begin
    $display("[ERROR] %s: write expected r%0d=%h (pending %0d), actual r%0d=%h", test_name,
      $sampled(exp_index), $sampled(exp_value), $sampled(exp_pending),
      $sampled(reg_write.index), $sampled(reg_write.value));
    failed = 1'b1;
  end

  assert property (@(posedge clk)
    reset |=> (!reg_write.valid && error_code == ERROR_NONE && !halted))
  else begin
    $display("[ERROR] %s: reset state expected valid 0 error 0 halted 0, actual %0d %0d %0d",
      test_name, $sampled(reg_write.valid), $sampled(error_code), $sampled(halted));
    failed = 1'b1;
  end

  assert property (@(posedge clk) disable iff (reset)
    (error_code != ERROR_NONE) |-> (error_code == exp_error))
  else begin
    $display("[ERROR] %s: error_code expected %0d, actual %0d", test_name,
      $sampled(exp_error), $sampled(error_code));
    failed = 1'b1;
  end

  // no writeback once halted or before run
  assert property (@(posedge clk) disable iff (reset)
    (halted || !run) |-> !reg_write.valid)
  else begin
    $display("[ERROR] %s: reg_write.valid expected 0 while halted or stopped, actual 1 (r%0d)",
      test_name, $sampled(reg_write.index));
    failed = 1'b1;
  end

endmodule

//--- verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;
  import cpu_mem_pkg::*;

  typedef enum logic [7:0] {
    OPCODE_JMP       = 8'd1,   // target = param:operand
    OPCODE_JMP_PLUS  = 8'd5,   // forward by operand instructions
    OPCODE_JMP_MINUS = 8'd6,   // backward by operand instructions
    OPCODE_NUM2REG   = 8'd16,  // reg = value
    OPCODE_REG_PLUS  = 8'd19,  // reg += value
    OPCODE_REG_MINUS = 8'd21   // reg -= value
  } opcode_t;

  typedef enum logic [1:0] {
    ERROR_NONE          = 2'd0,
    ERROR_WRONG_ADDRESS = 2'd1,
    ERROR_WRONG_REG_NUM = 2'd3
  } error_code_t;

  // parameter byte of the first instruction word
  typedef struct packed {
    logic [2:0] count;      // registers written minus one
    reg_index_t start_reg;
  } param_t;

  typedef struct packed {
    logic [7:0] opcode;     // raw byte, unknown values pass through
    param_t     param;
    word_t      operand;
    ram_addr_t  address;    // address of the first word
  } instruction_t;

  typedef struct packed {
    logic      redirect;
    ram_addr_t target;
  } exec_result_t;

  typedef struct packed {
    logic       valid;
    reg_index_t index;
    word_t      value;
  } reg_write_t;

endpackage

//--- verilog/cpu_mem_pkg.sv
package cpu_mem_pkg;

  // one data or instruction word
  typedef logic [15:0] word_t;

  // word address into program RAM
  typedef logic [15:0] ram_addr_t;

  // register number
  typedef logic [4:0] reg_index_t;

  localparam int REG_COUNT = 32;

  // program RAM size in words
  localparam int DEFAULT_RAM_DEPTH = 256;

  // first instruction sits after the old process record area
  localparam int DEFAULT_PROGRAM_BASE = 46;

endpackage

//--- verilog/cpu_top.sv
module cpu_top
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        load_enable,
  input  ram_addr_t   load_address,
  input  word_t       load_data,
  input  logic        run,
  output reg_write_t  reg_write,
  output error_code_t error_code,
  output logic        halted
);

  localparam int RAM_DEPTH    = DEFAULT_RAM_DEPTH;
  localparam int PROGRAM_BASE = DEFAULT_PROGRAM_BASE;

  ram_addr_t    read_address;
  word_t        read_data;
  logic         instruction_valid;
  instruction_t instruction;
  logic         fetch_fault;
  logic         result_valid;
  exec_result_t result;

  program_ram #(
    .RAM_DEPTH(RAM_DEPTH)
  ) program_ram_inst (
    .clk(clk),
    .load_enable(load_enable),
    .load_address(load_address),
    .load_data(load_data),
    .read_address(read_address),
    .read_data(read_data)
  );

  instruction_fetch #(
    .RAM_DEPTH(RAM_DEPTH),
    .PROGRAM_BASE(PROGRAM_BASE)
  ) instruction_fetch_inst (
    .clk(clk),
    .reset(reset),
    .run(run),
    .read_data(read_data),
    .result_valid(result_valid),
    .result(result),
    .read_address(read_address),
    .instruction_valid(instruction_valid),
    .instruction(instruction),
    .fetch_fault(fetch_fault)
  );

  execute_unit #(
    .PROGRAM_BASE(PROGRAM_BASE)
  ) execute_unit_inst (
    .clk(clk),
    .reset(reset),
    .instruction_valid(instruction_valid),
    .instruction(instruction),
    .fetch_fault(fetch_fault),
    .result_valid(result_valid),
    .result(result),
    .reg_write(reg_write),
    .error_code(error_code),
    .halted(halted)
  );

endmodule

//--- verilog/execute_unit.sv
module execute_unit
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;
#(
  parameter int PROGRAM_BASE = DEFAULT_PROGRAM_BASE
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         instruction_valid,
  input  instruction_t instruction,
  input  logic         fetch_fault,
  output logic         result_valid,
  output exec_result_t result,
  output reg_write_t   reg_write,
  output error_code_t  error_code,
  output logic         halted
);

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_RANGE,
    EXEC_HALT
  } exec_state_t;

  exec_state_t state;
  word_t       regs [REG_COUNT];

  // range in progress
  logic [7:0]  range_opcode;
  word_t       range_operand;
  reg_index_t  cur_index;
  reg_index_t  last_index;
  word_t       write_value;

  // decode of the presented instruction
  logic [5:0]  range_end;
  logic        reg_num_bad;
  ram_addr_t   jmp_target;
  ram_addr_t   plus_target;
  logic [17:0] minus_full;     // signed result, bit 17 set means below zero
  logic        minus_low;
  error_code_t decode_error;
  logic        decode_redirect;
  ram_addr_t   decode_target;
  logic        decode_range;

  assign range_end   = {1'b0, instruction.param.start_reg} + {3'b0, instruction.param.count};
  assign reg_num_bad = range_end >= 6'(REG_COUNT);

  // param byte lands above the address width and drops out
  assign jmp_target  = ram_addr_t'({instruction.param, instruction.operand});
  assign plus_target = instruction.address + 16'd2 + {instruction.operand[14:0], 1'b0};
  assign minus_full  = {2'b0, instruction.address} - {1'b0, instruction.operand, 1'b0};
  assign minus_low   = minus_full[17] || (minus_full[16:0] < 17'(PROGRAM_BASE));

  always_comb begin
    decode_error    = ERROR_NONE;
    decode_redirect = 1'b0;
    decode_target   = jmp_target;
    decode_range    = 1'b0;
    case (instruction.opcode)
      OPCODE_JMP: begin
        decode_redirect = 1'b1;
        if (jmp_target[0]) begin
          decode_error = ERROR_WRONG_ADDRESS;  // targets must be word pairs
        end
      end
      OPCODE_JMP_PLUS: begin
        decode_redirect = 1'b1;
        decode_target   = plus_target;
      end
      OPCODE_JMP_MINUS: begin
        decode_redirect = 1'b1;
        decode_target   = minus_full[15:0];
        if (minus_low) begin
          decode_error = ERROR_WRONG_ADDRESS;
        end
      end
      OPCODE_NUM2REG, OPCODE_REG_PLUS, OPCODE_REG_MINUS: begin
        decode_range = 1'b1;
        if (reg_num_bad) begin
          decode_error = ERROR_WRONG_REG_NUM;
        end
      end
      default: begin
        decode_redirect = 1'b0;  // unknown opcode just moves on
      end
    endcase
  end

  always_comb begin
    case (range_opcode)
      OPCODE_REG_PLUS:  write_value = regs[cur_index] + range_operand;
      OPCODE_REG_MINUS: write_value = regs[cur_index] - range_operand;
      default:          write_value = range_operand;
    endcase
  end

  assign reg_write = '{valid: (state == EXEC_RANGE), index: cur_index, value: write_value};
  assign halted    = (state == EXEC_HALT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= EXEC_IDLE;
      result_valid <= 1'b0;
      error_code   <= ERROR_NONE;
      regs         <= '{default: '0};
    end else begin
      result_valid <= 1'b0;
      case (state)
        EXEC_IDLE: begin
          if (fetch_fault) begin
            error_code <= ERROR_WRONG_ADDRESS;  // pc ran off the end of RAM
            state      <= EXEC_HALT;
          end else if (instruction_valid) begin
            if (decode_error != ERROR_NONE) begin
              error_code <= decode_error;
              state      <= EXEC_HALT;
            end else if (decode_range) begin
              state <= EXEC_RANGE;
            end else begin
              result_valid <= 1'b1;
            end
          end
        end
        EXEC_RANGE: begin
          regs[cur_index] <= write_value;
          if (cur_index == last_index) begin
            result_valid <= 1'b1;  // result already holds redirect low
            state        <= EXEC_IDLE;
          end
        end
        default: begin
          state <= EXEC_HALT;  // only reset leaves here
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == EXEC_IDLE && instruction_valid) begin
      range_opcode  <= instruction.opcode;
      range_operand <= instruction.operand;
      cur_index     <= instruction.param.start_reg;
      last_index    <= range_end[4:0];
      result        <= '{redirect: decode_redirect, target: decode_target};
    end else if (state == EXEC_RANGE) begin
      cur_index <= cur_index + 5'd1;
    end
  end

endmodule

//--- verilog/instruction_fetch.sv
module instruction_fetch
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;
#(
  parameter int RAM_DEPTH    = DEFAULT_RAM_DEPTH,
  parameter int PROGRAM_BASE = DEFAULT_PROGRAM_BASE
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         run,
  input  word_t        read_data,
  input  logic         result_valid,
  input  exec_result_t result,
  output ram_addr_t    read_address,
  output logic         instruction_valid,
  output instruction_t instruction,
  output logic         fetch_fault
);

  typedef enum logic [1:0] {
    FETCH_ISSUE,
    FETCH_FIRST,
    FETCH_SECOND,
    FETCH_WAIT
  } fetch_state_t;

  fetch_state_t state;
  ram_addr_t    pc;
  word_t        first_word;
  logic [16:0]  pc_plus_one;    // one extra bit so the range check cannot wrap
  logic         out_of_range;

  assign pc_plus_one  = {1'b0, pc} + 17'd1;
  assign out_of_range = pc_plus_one >= 17'(RAM_DEPTH);  // second word would miss the RAM

  // first word in issue, second word while the first comes back
  assign read_address = (state == FETCH_FIRST) ? pc_plus_one[15:0] : pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state             <= FETCH_ISSUE;
      pc                <= ram_addr_t'(PROGRAM_BASE);
      instruction_valid <= 1'b0;
      fetch_fault       <= 1'b0;
    end else begin
      instruction_valid <= 1'b0;
      fetch_fault       <= 1'b0;
      case (state)
        FETCH_ISSUE: begin
          if (run && out_of_range) begin
            fetch_fault <= 1'b1;
            state       <= FETCH_WAIT;  // execute halts, no result ever comes
          end else if (run) begin
            state <= FETCH_FIRST;
          end
        end
        FETCH_FIRST: begin
          state <= FETCH_SECOND;
        end
        FETCH_SECOND: begin
          instruction_valid <= 1'b1;
          state             <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (result_valid) begin
            pc    <= result.redirect ? result.target : pc + 16'd2;
            state <= FETCH_ISSUE;
          end
        end
        default: begin
          state <= FETCH_ISSUE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH_FIRST) begin
      first_word <= read_data;
    end
    if (state == FETCH_SECOND) begin
      instruction.opcode  <= first_word[15:8];
      instruction.param   <= first_word[7:0];
      instruction.operand <= read_data;
      instruction.address <= pc;
    end
  end

endmodule

//--- verilog/program_ram.sv
module program_ram
  import cpu_mem_pkg::*;
#(
  parameter int RAM_DEPTH = DEFAULT_RAM_DEPTH
) (
  input  logic      clk,
  input  logic      load_enable,
  input  ram_addr_t load_address,
  input  word_t     load_data,
  input  ram_addr_t read_address,
  output word_t     read_data
);

  localparam int ADDR_BITS = $clog2(RAM_DEPTH);

  word_t mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (load_enable && load_address < RAM_DEPTH) begin  // words past the end are dropped
      mem[load_address[ADDR_BITS-1:0]] <= load_data;
    end
    read_data <= mem[read_address[ADDR_BITS-1:0]];  // data one cycle after address
  end

endmodule
